// ==== src/uart_rx_pkg.sv ====
// ********************
// Shared sizes, state and register encodings for the UART receive subsystem
// Every RTL file refers to these by scoped name
// ********************
`default_nettype none

package uart_rx_pkg;

	// ********************
	// Channel and FIFO sizes
	// ********************
	localparam int NUM_CH     = 4;
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_PTR_W = 4;
	localparam int FIFO_CNT_W = 5;

	// Entry is data in the upper bits, error flags in the lower bits
	localparam int DATA_W     = 8;
	localparam int FLAG_W     = 3;
	localparam int FIFO_WIDTH = DATA_W + FLAG_W;
	localparam int FLAG_BRK   = 2;
	localparam int FLAG_FRM   = 1;
	localparam int FLAG_PAR   = 0;

	// Baud timing
	localparam int DIV_W      = 16;
	localparam int DIV_RESET  = 3;
	localparam int OVERSAMPLE = 16;
	localparam int OS_CNT_W   = $clog2(OVERSAMPLE);
	localparam int MID_TICK   = OVERSAMPLE / 2;

	// ********************
	// APB address map
	// ********************
	localparam int APB_ADDR_W = 7;
	localparam int APB_DATA_W = 32;
	localparam logic [APB_ADDR_W-1:0] DIV_ADDR = 7'h40;
	// Channel in paddr[5:4], register in paddr[3:2]
	localparam int CH_SEL_HI  = 5;
	localparam int CH_SEL_LO  = 4;
	localparam int REG_SEL_HI = 3;
	localparam int REG_SEL_LO = 2;

	typedef enum logic [2:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_parity,
		rx_stop,
		rx_wait_idle
	} rx_state_e;

	typedef enum logic [1:0] {
		reg_rbr = 2'd0,
		reg_lsr = 2'd1,
		reg_fcr = 2'd2
	} reg_off_e;

endpackage

`default_nettype wire

// ==== src/uart_baud_gen.sv ====
// ********************
// Oversample tick generator shared by all receive channels
// Tick is one cycle wide, once every divisor+1 clocks
// ********************
`timescale 1ns/1ps
`default_nettype none

module uart_baud_gen (
	input  wire                          rvx_port_08,
	input  wire                          rvx_port_06,
	input  wire [uart_rx_pkg::DIV_W-1:0] divisor,
	output logic                         tick
);

	logic [uart_rx_pkg::DIV_W-1:0] cnt;

	// Down-counter, divisor is sampled only on wrap
	always_ff @(posedge rvx_port_08 or posedge rvx_port_06)
	begin
		if (rvx_port_06)
		begin
			cnt  <= '0;
			tick <= 1'b0;
		end
		else if (cnt == '0)
		begin
			cnt  <= divisor;
			tick <= 1'b1;
		end
		else
		begin
			cnt  <= cnt - 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== src/uart_rx_deser.sv ====
// ********************
// Serial receiver for one channel, fixed 8E1 frames
// Produces one FIFO entry per frame with break, framing and parity flags
// ********************
`timescale 1ns/1ps
`default_nettype none

module uart_rx_deser (
	input  wire                               rvx_port_08,
	input  wire                               rvx_port_06,
	input  wire                               tick,
	input  wire                               rx,
	output logic                              push,
	output logic [uart_rx_pkg::FIFO_WIDTH-1:0] push_data
);

	uart_rx_pkg::rx_state_e state;

	logic                                rx_meta;
	logic                                rx_sync;
	logic [uart_rx_pkg::OS_CNT_W-1:0]    os_cnt;
	logic [2:0]                          bit_idx;
	logic [uart_rx_pkg::DATA_W-1:0]      data_sr;
	logic                                par_bit;
	logic                                bit_mid;
	logic                                brk;
	logic                                frm;
	logic                                par_err;

	// Last tick of a bit period, counted from the start-bit midpoint
	assign bit_mid = (os_cnt == uart_rx_pkg::OS_CNT_W'(uart_rx_pkg::OVERSAMPLE - 1));

	// ********************
	// Control FSM
	// ********************
	always_ff @(posedge rvx_port_08 or posedge rvx_port_06)
	begin
		if (rvx_port_06)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			state   <= uart_rx_pkg::rx_idle;
			os_cnt  <= '0;
			bit_idx <= '0;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			if (tick)
			begin
				os_cnt <= os_cnt + 1'b1;
				case (state)
					uart_rx_pkg::rx_idle:
					begin
						os_cnt <= '0;
						if (!rx_sync)
							state <= uart_rx_pkg::rx_start;
					end
					uart_rx_pkg::rx_start:
					begin
						// False start if the line went back high by mid-bit
						if (os_cnt == uart_rx_pkg::OS_CNT_W'(uart_rx_pkg::MID_TICK - 1))
						begin
							os_cnt  <= '0;
							bit_idx <= '0;
							state   <= rx_sync ? uart_rx_pkg::rx_idle : uart_rx_pkg::rx_data;
						end
					end
					uart_rx_pkg::rx_data:
					begin
						if (bit_mid)
						begin
							bit_idx <= bit_idx + 1'b1;
							if (bit_idx == 3'(uart_rx_pkg::DATA_W - 1))
								state <= uart_rx_pkg::rx_parity;
						end
					end
					uart_rx_pkg::rx_parity:
					begin
						if (bit_mid)
							state <= uart_rx_pkg::rx_stop;
					end
					uart_rx_pkg::rx_stop:
					begin
						if (bit_mid)
							state <= rx_sync ? uart_rx_pkg::rx_idle : uart_rx_pkg::rx_wait_idle;
					end
					uart_rx_pkg::rx_wait_idle:
					begin
						// Hold here through a break until the line idles high
						os_cnt <= '0;
						if (rx_sync)
							state <= uart_rx_pkg::rx_idle;
					end
					default:
						state <= uart_rx_pkg::rx_idle;
				endcase
			end
		end
	end

	// Data shift register, LSB first
	always_ff @(posedge rvx_port_08)
	begin
		if (tick && bit_mid)
		begin
			if (state == uart_rx_pkg::rx_data)
				data_sr <= {rx_sync, data_sr[uart_rx_pkg::DATA_W-1:1]};
			if (state == uart_rx_pkg::rx_parity)
				par_bit <= rx_sync;
		end
	end

	// ********************
	// Entry build, valid in the stop-bit sample cycle
	// ********************
	assign par_err = par_bit != (^data_sr);
	assign frm     = !rx_sync;
	assign brk     = !rx_sync && !par_bit && (data_sr == '0);

	assign push = tick && bit_mid && (state == uart_rx_pkg::rx_stop);

	always_comb
	begin
		push_data = {data_sr, {uart_rx_pkg::FLAG_W{1'b0}}};
		push_data[uart_rx_pkg::FLAG_BRK] = brk;
		push_data[uart_rx_pkg::FLAG_FRM] = frm;
		push_data[uart_rx_pkg::FLAG_PAR] = par_err;
	end

endmodule

`default_nettype wire

// ==== src/uart_rx_fifo.sv ====
// ********************
// Receive FIFO for one channel, 16 entries of data plus error flags
// Keeps a count, a sticky overflow and an error summary of held entries
// ********************
`timescale 1ns/1ps
`default_nettype none

module uart_rx_fifo (
	input  wire                                rvx_port_08,
	input  wire                                rvx_port_06,
	input  wire                                push,
	input  wire  [uart_rx_pkg::FIFO_WIDTH-1:0] push_data,
	input  wire                                pop,
	input  wire                                fifo_clear,
	input  wire                                status_clear,
	output logic [uart_rx_pkg::FIFO_WIDTH-1:0] head,
	output logic [uart_rx_pkg::FIFO_CNT_W-1:0] count,
	output logic                               overflow,
	output logic                               error_any
);

	logic [uart_rx_pkg::FIFO_WIDTH-1:0] mem [uart_rx_pkg::FIFO_DEPTH];
	logic [uart_rx_pkg::FIFO_PTR_W-1:0] wr_ptr;
	logic [uart_rx_pkg::FIFO_PTR_W-1:0] rd_ptr;
	logic                               full;
	logic                               do_push;
	logic                               do_pop;

	assign full    = (count == uart_rx_pkg::FIFO_CNT_W'(uart_rx_pkg::FIFO_DEPTH));
	assign do_pop  = pop && (count != '0);
	// A full FIFO still accepts a push when it pops in the same cycle
	assign do_push = push && (!full || do_pop);

	// ********************
	// Storage and pointers
	// ********************
	always_ff @(posedge rvx_port_08 or posedge rvx_port_06)
	begin
		if (rvx_port_06)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			for (int i = 0; i < uart_rx_pkg::FIFO_DEPTH; i++)
				mem[i] <= '0;
		end
		else if (fifo_clear)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			for (int i = 0; i < uart_rx_pkg::FIFO_DEPTH; i++)
				mem[i] <= '0;
		end
		else
		begin
			// Zero the popped slot, a push to the same slot wins
			if (do_pop)
			begin
				mem[rd_ptr] <= '0;
				rd_ptr      <= rd_ptr + 1'b1;
			end
			if (do_push)
			begin
				mem[wr_ptr] <= push_data;
				wr_ptr      <= wr_ptr + 1'b1;
			end
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// Sticky overflow
	always_ff @(posedge rvx_port_08 or posedge rvx_port_06)
	begin
		if (rvx_port_06)
			overflow <= 1'b0;
		else if (fifo_clear || status_clear)
			overflow <= 1'b0;
		else if (push && full && !pop)
			overflow <= 1'b1;
	end

	assign head = mem[rd_ptr];

	// Empty slots are zero, so an OR over every slot covers held entries only
	always_comb
	begin
		error_any = 1'b0;
		for (int i = 0; i < uart_rx_pkg::FIFO_DEPTH; i++)
			error_any = error_any | (|mem[i][uart_rx_pkg::FLAG_W-1:0]);
	end

endmodule

`default_nettype wire

// ==== src/uart_rx_apb_regs.sv ====
// ********************
// Zero-wait APB slave for the receive channels
// Holds the divisor, muxes per-channel status and pops or clears FIFOs
// ********************
`timescale 1ns/1ps
`default_nettype none

module uart_rx_apb_regs (
	input  wire                                               rvx_port_08,
	input  wire                                               rvx_port_06,
	input  wire                                               psel,
	input  wire                                               penable,
	input  wire                                               pwrite,
	input  wire  [uart_rx_pkg::APB_ADDR_W-1:0]                paddr,
	input  wire  [uart_rx_pkg::APB_DATA_W-1:0]                pwdata,
	output logic [uart_rx_pkg::APB_DATA_W-1:0]                prdata,
	output logic [uart_rx_pkg::DIV_W-1:0]                     divisor,
	input  wire  [uart_rx_pkg::NUM_CH*uart_rx_pkg::FIFO_WIDTH-1:0] fifo_head,
	input  wire  [uart_rx_pkg::NUM_CH*uart_rx_pkg::FIFO_CNT_W-1:0] fifo_count,
	input  wire  [uart_rx_pkg::NUM_CH-1:0]                    fifo_overflow,
	input  wire  [uart_rx_pkg::NUM_CH-1:0]                    fifo_error,
	output logic [uart_rx_pkg::NUM_CH-1:0]                    pop,
	output logic [uart_rx_pkg::NUM_CH-1:0]                    fifo_clear,
	output logic [uart_rx_pkg::NUM_CH-1:0]                    status_clear
);

	localparam int CH_W = uart_rx_pkg::CH_SEL_HI - uart_rx_pkg::CH_SEL_LO + 1;

	uart_rx_pkg::reg_off_e              reg_off;
	logic [CH_W-1:0]                    ch;
	logic                               ch_hit;
	logic                               div_hit;
	logic                               rd_access;
	logic                               wr_access;
	logic [uart_rx_pkg::FIFO_WIDTH-1:0] sel_head;
	logic [uart_rx_pkg::FIFO_CNT_W-1:0] sel_count;
	logic                               sel_empty;

	// ********************
	// Address decode
	// ********************
	assign rd_access = psel && penable && !pwrite;
	assign wr_access = psel && penable && pwrite;

	assign ch      = paddr[uart_rx_pkg::CH_SEL_HI:uart_rx_pkg::CH_SEL_LO];
	assign reg_off = uart_rx_pkg::reg_off_e'(paddr[uart_rx_pkg::REG_SEL_HI:uart_rx_pkg::REG_SEL_LO]);
	// Channel space is the lower half of the map
	assign ch_hit  = !paddr[uart_rx_pkg::APB_ADDR_W-1];
	assign div_hit = (paddr == uart_rx_pkg::DIV_ADDR);

	assign sel_head  = fifo_head[ch*uart_rx_pkg::FIFO_WIDTH +: uart_rx_pkg::FIFO_WIDTH];
	assign sel_count = fifo_count[ch*uart_rx_pkg::FIFO_CNT_W +: uart_rx_pkg::FIFO_CNT_W];
	assign sel_empty = (sel_count == '0);

	// Divisor register
	always_ff @(posedge rvx_port_08 or posedge rvx_port_06)
	begin
		if (rvx_port_06)
			divisor <= uart_rx_pkg::DIV_W'(uart_rx_pkg::DIV_RESET);
		else if (wr_access && div_hit)
			divisor <= pwdata[uart_rx_pkg::DIV_W-1:0];
	end

	// ********************
	// Read mux
	// ********************
	always_comb
	begin
		prdata = '0;
		if (div_hit)
			prdata[uart_rx_pkg::DIV_W-1:0] = divisor;
		else if (ch_hit)
		begin
			case (reg_off)
				uart_rx_pkg::reg_rbr:
				begin
					// Flags move up to bits 10:8, data to 7:0
					if (!sel_empty)
						prdata[uart_rx_pkg::FIFO_WIDTH-1:0] =
							{sel_head[uart_rx_pkg::FLAG_W-1:0],
							 sel_head[uart_rx_pkg::FIFO_WIDTH-1:uart_rx_pkg::FLAG_W]};
				end
				uart_rx_pkg::reg_lsr:
				begin
					prdata[uart_rx_pkg::FIFO_CNT_W+1:0] =
						{fifo_error[ch], fifo_overflow[ch], sel_count};
				end
				default:
					prdata = '0;
			endcase
		end
	end

	// Per-channel strobes, one cycle in the access phase
	always_comb
	begin
		pop          = '0;
		fifo_clear   = '0;
		status_clear = '0;
		if (ch_hit)
		begin
			pop[ch]          = rd_access && (reg_off == uart_rx_pkg::reg_rbr) && !sel_empty;
			status_clear[ch] = rd_access && (reg_off == uart_rx_pkg::reg_lsr);
			fifo_clear[ch]   = wr_access && (reg_off == uart_rx_pkg::reg_fcr) && pwdata[0];
		end
	end

endmodule

`default_nettype wire

// ==== src/uart_rx_top.sv ====
// ********************
// Four-channel UART receive subsystem with an APB register port
// One baud generator, one receiver and FIFO per channel, one register block
// ********************
`timescale 1ns/1ps
`default_nettype none

module uart_rx_top (
	input  wire                                rvx_port_08,
	input  wire                                rvx_port_06,
	input  wire  [uart_rx_pkg::NUM_CH-1:0]     rx,
	input  wire                                psel,
	input  wire                                penable,
	input  wire                                pwrite,
	input  wire  [uart_rx_pkg::APB_ADDR_W-1:0] paddr,
	input  wire  [uart_rx_pkg::APB_DATA_W-1:0] pwdata,
	output logic [uart_rx_pkg::APB_DATA_W-1:0] prdata
);

	localparam int FW = uart_rx_pkg::FIFO_WIDTH;
	localparam int CW = uart_rx_pkg::FIFO_CNT_W;

	logic                                  tick;
	logic [uart_rx_pkg::DIV_W-1:0]         divisor;
	logic [uart_rx_pkg::NUM_CH-1:0]        push;
	logic [uart_rx_pkg::NUM_CH*FW-1:0]     push_data;
	logic [uart_rx_pkg::NUM_CH*FW-1:0]     head;
	logic [uart_rx_pkg::NUM_CH*CW-1:0]     count;
	logic [uart_rx_pkg::NUM_CH-1:0]        overflow;
	logic [uart_rx_pkg::NUM_CH-1:0]        error_any;
	logic [uart_rx_pkg::NUM_CH-1:0]        pop;
	logic [uart_rx_pkg::NUM_CH-1:0]        fifo_clear;
	logic [uart_rx_pkg::NUM_CH-1:0]        status_clear;

	uart_baud_gen uart_baud_gen_i (
		.rvx_port_08 (rvx_port_08),
		.rvx_port_06 (rvx_port_06),
		.divisor     (divisor),
		.tick        (tick)
	);

	// ********************
	// Receive channels
	// ********************
	for (genvar n = 0; n < uart_rx_pkg::NUM_CH; n++)
	begin : g_ch
		uart_rx_deser uart_rx_deser_i (
			.rvx_port_08 (rvx_port_08),
			.rvx_port_06 (rvx_port_06),
			.tick        (tick),
			.rx          (rx[n]),
			.push        (push[n]),
			.push_data   (push_data[n*FW +: FW])
		);

		uart_rx_fifo uart_rx_fifo_i (
			.rvx_port_08  (rvx_port_08),
			.rvx_port_06  (rvx_port_06),
			.push         (push[n]),
			.push_data    (push_data[n*FW +: FW]),
			.pop          (pop[n]),
			.fifo_clear   (fifo_clear[n]),
			.status_clear (status_clear[n]),
			.head         (head[n*FW +: FW]),
			.count        (count[n*CW +: CW]),
			.overflow     (overflow[n]),
			.error_any    (error_any[n])
		);
	end

	uart_rx_apb_regs uart_rx_apb_regs_i (
		.rvx_port_08   (rvx_port_08),
		.rvx_port_06   (rvx_port_06),
		.psel          (psel),
		.penable       (penable),
		.pwrite        (pwrite),
		.paddr         (paddr),
		.pwdata        (pwdata),
		.prdata        (prdata),
		.divisor       (divisor),
		.fifo_head     (head),
		.fifo_count    (count),
		.fifo_overflow (overflow),
		.fifo_error    (error_any),
		.pop           (pop),
		.fifo_clear    (fifo_clear),
		.status_clear  (status_clear)
	);

endmodule

`default_nettype wire

// ==== dv/uart_rx_tb.sv ====
// ********************
// Testbench for the four-channel UART receive subsystem
// Runs the command list in dv/uart_rx_stim.txt, driving serial frames and APB
// accesses, and checks every register read against the expected value
// ********************
`timescale 1ns/1ps
`default_nettype none

module uart_rx_tb;

	localparam int NCH        = uart_rx_pkg::NUM_CH;
	localparam int WAIT_POLLS = 100;
	// Frame kinds used by the stimulus file
	localparam int KIND_NORMAL  = 0;
	localparam int KIND_BAD_PAR = 1;
	localparam int KIND_BAD_STP = 2;
	localparam int KIND_BREAK   = 3;

	logic            rvx_port_08;
	logic            rvx_port_06;
	logic [NCH-1:0]  rx;
	logic            psel;
	logic            penable;
	logic            pwrite;
	logic [6:0]      paddr;
	logic [31:0]     pwdata;
	logic [31:0]     prdata;

	int              errors;
	int              checks;
	int              div_cur;
	logic            aborted;

	uart_rx_top uart_rx_top_i (
		.rvx_port_08 (rvx_port_08),
		.rvx_port_06 (rvx_port_06),
		.rx          (rx),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata)
	);

	always #50 rvx_port_08 = ~rvx_port_08;

	// Channel in address bits 5:4, register in bits 3:2
	function automatic logic [6:0] reg_addr(input int ch, input int off);
		return 7'((ch << 4) | (off << 2));
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			$display("Fail %0s: got 0x%0h expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	// A short stimulus line ends the run
	task automatic verify_arg_count(input int got, input int want, input logic [7:0] op);
		if (got != want)
		begin
			$display("Stimulus command %0s has %0d arguments where %0d are needed",
				op, got, want);
			errors++;
			aborted = 1'b1;
		end
	endtask

	// ********************
	// APB accesses
	// ********************
	task automatic apb_write(input logic [6:0] addr, input logic [31:0] data);
		@(posedge rvx_port_08);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge rvx_port_08);
		penable <= 1'b1;
		@(posedge rvx_port_08);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input logic [6:0] addr, output logic [31:0] data);
		@(posedge rvx_port_08);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge rvx_port_08);
		penable <= 1'b1;
		// prdata is settled by the middle of the access phase
		@(negedge rvx_port_08);
		data = prdata;
		@(posedge rvx_port_08);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic read_expect(input int ch, input int off, input string reg_name,
		input logic [31:0] exp);
		logic [31:0] rdata;
		apb_read(reg_addr(ch, off), rdata);
		check_value($sformatf("prdata ch%0d %0s", ch, reg_name), rdata, exp);
	endtask

	// ********************
	// Serial frame driver
	// ********************
	task automatic drive_bit(input int ch, input logic val);
		@(posedge rvx_port_08);
		rx[ch] <= val;
		repeat (uart_rx_pkg::OVERSAMPLE * (div_cur + 1) - 1)
			@(posedge rvx_port_08);
	endtask

	task automatic send_frame(input int ch, input int kind, input logic [7:0] data);
		logic [10:0] bits;
		logic        par;
		par = ^data;
		if (kind == KIND_BAD_PAR)
			par = ~par;
		// Stop, parity, data LSB first, start
		bits = {(kind == KIND_BAD_STP) ? 1'b0 : 1'b1, par, data, 1'b0};
		if (kind == KIND_BREAK)
			repeat (12) drive_bit(ch, 1'b0);
		else
			for (int i = 0; i < 11; i++)
				drive_bit(ch, bits[i]);
		repeat (2) drive_bit(ch, 1'b1);
	endtask

	// Poll lsr until the channel count reaches the target
	task automatic wait_count(input int ch, input int target);
		logic [31:0] lsr;
		int          polls;
		logic        done;
		polls = 0;
		done  = 1'b0;
		while (!done && polls < WAIT_POLLS)
		begin
			apb_read(reg_addr(ch, int'(uart_rx_pkg::reg_lsr)), lsr);
			polls++;
			done = (lsr[4:0] == 5'(target));
		end
		if (!done)
		begin
			$display("Timeout: channel %0d FIFO count never reached %0d", ch, target);
			errors++;
			aborted = 1'b1;
		end
	endtask

	// ********************
	// Stimulus file commands
	// ********************
	task automatic run_command(input int fd, input logic [7:0] op);
		logic [31:0]     a;
		logic [31:0]     b;
		logic [31:0]     c;
		logic [31:0]     rdata;
		logic [8*128-1:0] rest;
		int              rc;
		case (op)
			"#": rc = $fgets(rest, fd);
			"W":
			begin
				rc = $fscanf(fd, "%h %h", a, b);
				verify_arg_count(rc, 2, op);
				apb_write(a[6:0], b);
				if (a[6:0] == uart_rx_pkg::DIV_ADDR)
					div_cur = int'(b[15:0]);
			end
			"R":
			begin
				rc = $fscanf(fd, "%h %h", a, b);
				verify_arg_count(rc, 2, op);
				apb_read(a[6:0], rdata);
				check_value($sformatf("prdata 0x%02h", a[6:0]), rdata, b);
			end
			"S":
			begin
				rc = $fscanf(fd, "%h %h %h", a, b, c);
				verify_arg_count(rc, 3, op);
				send_frame(int'(a), int'(b), c[7:0]);
			end
			"N":
			begin
				rc = $fscanf(fd, "%h %h %h", a, b, c);
				verify_arg_count(rc, 3, op);
				for (int i = 0; i < int'(b); i++)
					send_frame(int'(a), KIND_NORMAL, 8'(c + i));
			end
			"C":
			begin
				rc = $fscanf(fd, "%h %h", a, b);
				verify_arg_count(rc, 2, op);
				wait_count(int'(a), int'(b));
			end
			"B":
			begin
				rc = $fscanf(fd, "%h %h", a, b);
				verify_arg_count(rc, 2, op);
				read_expect(int'(a), int'(uart_rx_pkg::reg_rbr), "rbr", b);
			end
			"L":
			begin
				rc = $fscanf(fd, "%h %h", a, b);
				verify_arg_count(rc, 2, op);
				read_expect(int'(a), int'(uart_rx_pkg::reg_lsr), "lsr", b);
			end
			"Q":
			begin
				// Run of clean entries with consecutive data bytes
				rc = $fscanf(fd, "%h %h %h", a, b, c);
				verify_arg_count(rc, 3, op);
				for (int i = 0; i < int'(b); i++)
					read_expect(int'(a), int'(uart_rx_pkg::reg_rbr), "rbr", {24'h0, 8'(c + i)});
			end
			default:
			begin
				$display("Unknown command character %0s in stimulus file", op);
				errors++;
			end
		endcase
	endtask

	initial
	begin
		int          fd;
		int          rc;
		logic [63:0] cmd;
		rvx_port_08 = 1'b0;
		rvx_port_06 = 1'b1;
		rx          = '1;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		errors      = 0;
		checks      = 0;
		div_cur     = uart_rx_pkg::DIV_RESET;
		aborted     = 1'b0;
		repeat (2) @(posedge rvx_port_08);
		rvx_port_06 <= 1'b0;

		fd = $fopen("dv/uart_rx_stim.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the stimulus file dv/uart_rx_stim.txt");
			errors++;
		end
		else
		begin
			while (!aborted && !$feof(fd))
			begin
				cmd = '0;
				rc  = $fscanf(fd, "%s", cmd);
				if (rc == 1)
					run_command(fd, cmd[7:0]);
			end
			$fclose(fd);
		end

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/uart_rx_stim.txt ====
# Columns: command letter, then hex arguments. W addr data, R addr expect, S ch kind byte
# N ch n first, C ch count, B ch rbr, L ch lsr, Q ch n first. Kinds 0 ok 1 par 2 stop 3 break
# Divisor 0, normal frames on every channel
W 40 0
S 0 0 a5
S 0 0 3c
C 0 2
L 1 0
L 2 0
L 3 0
B 0 a5
B 0 3c
N 1 2 10
C 1 2
N 2 1 20
C 2 1
N 3 1 30
C 3 1
Q 1 2 10
Q 2 1 20
Q 3 1 30
# Parity and stop errors on channel 1
S 1 1 96
S 1 2 5b
C 1 2
L 1 42
B 1 196
L 1 41
B 1 25b
L 1 0
# Break on channel 1 gives one entry
S 1 3 0
C 1 1
L 1 41
B 1 600
L 1 0
# Overflow on channel 2
N 2 10 40
C 2 10
S 2 0 ee
L 2 30
L 2 10
Q 2 10 40
L 2 0
B 2 0
# FIFO reset on channel 3
S 3 1 55
C 3 1
N 3 10 80
L 3 70
W 38 1
L 3 0
B 3 0
# Divisor 2, read back and receive
W 40 2
R 40 2
S 0 0 5a
S 0 1 c3
C 0 2
B 0 5a
B 0 1c3
L 0 0

// ==== sources.f ====
src/uart_rx_pkg.sv
src/uart_baud_gen.sv
src/uart_rx_deser.sv
src/uart_rx_fifo.sv
src/uart_rx_apb_regs.sv
src/uart_rx_top.sv
dv/uart_rx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the UART receive testbench with Verilator, run from the project root
rm -f sim.log
verilator --binary --timing -Wno-fatal -f sources.f --top-module uart_rx_tb -o uart_rx_sim \
	&& ./obj_dir/uart_rx_sim > sim.log 2>&1 \
	; cat sim.log 2>/dev/null \
	; grep -q "^All tests passed$" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
